/* pattern_source_top.f */
src/stream_pkg.sv
src/regmap_pkg.sv
src/axi_register_slice.sv
src/pattern_gen.sv
src/stream_monitor.sv
src/pattern_ctrl.sv
src/pattern_source_top.sv
tests/pattern_source_properties.sv
tests/pattern_source_tb.sv

/* Bender.yml */
package:
  name: pattern_source

sources:
  # Packages first, then the blocks, then the top level
  - src/stream_pkg.sv
  - src/regmap_pkg.sv
  - src/axi_register_slice.sv
  - src/pattern_gen.sv
  - src/stream_monitor.sv
  - src/pattern_ctrl.sv
  - src/pattern_source_top.sv

  # Verification only
  - target: test
    files:
      - tests/pattern_source_properties.sv
      - tests/pattern_source_tb.sv

/* tests/pattern_source_tb.sv */
module pattern_source_tb
  import stream_pkg::*;
  import regmap_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;
  localparam int BUS_TIMEOUT  = 20;
  localparam int BEAT_TIMEOUT = 200;
  localparam int POLL_TIMEOUT = 20;

  logic                 clk;
  logic                 resetn;
  wb_req_t              wb_req;
  logic                 wb_ack;
  logic [WB_DATA_W-1:0] wb_dat_r;
  logic                 m_valid;
  logic                 m_ready;
  stream_beat_t         m_beat;

  // Seed for the back-pressure pattern on m_ready
  integer               seed = 32'h9fa5;

  pattern_source_top dut_i (
    .clk      (clk),
    .resetn   (resetn),
    .wb_req   (wb_req),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .m_valid  (m_valid),
    .m_ready  (m_ready),
    .m_beat   (m_beat)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // **********************************************************************
  // Helpers
  // **********************************************************************

  // Inputs change a little after the edge and outputs are sampled there too
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
      abort_run();
    end
  endtask

  // One Wishbone classic cycle with stb low for at least a cycle before it
  task automatic bus_cycle(input logic write, input logic [WB_ADDR_W-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    cycles = 0;
    next_cycle();
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = write;
    wb_req.adr = adr;
    wb_req.dat = wdata;
    wb_req.sel = '1;
    do begin
      next_cycle();
      cycles++;
      if (!wb_ack && cycles >= BUS_TIMEOUT) begin
        $display("Timeout: the Wishbone slave never acknowledged address %0d", adr);
        abort_run();
      end
    end while (!wb_ack);
    // Read data is valid while ack is high
    rdata  = wb_dat_r;
    wb_req = '0;
  endtask

  task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  task automatic read_check(input logic [WB_ADDR_W-1:0] adr, input logic [31:0] expected,
                            input string what);
    logic [31:0] value;
    wb_read(adr, value);
    check_equal(value, expected, what);
  endtask

  task automatic start_burst(input int length, input logic [31:0] first);
    wb_write(REG_LENGTH, 32'(length));
    wb_write(REG_START, first);
    wb_write(REG_CTRL, 32'h1);
  endtask

  // Expected sum of a ramp that wraps at 32 bits
  function automatic logic [31:0] ramp_sum(input logic [31:0] first, input int length);
    logic [31:0] sum;
    sum = '0;
    for (int k = 0; k < length; k++) begin
      sum += first + 32'(k);
    end
    return sum;
  endfunction

  task automatic wait_for_valid();
    int cycles;
    cycles = 0;
    while (!m_valid) begin
      next_cycle();
      cycles++;
      if (!m_valid && cycles >= BEAT_TIMEOUT) begin
        $display("Timeout: the stream never raised m_valid after a start");
        abort_run();
      end
    end
  endtask

  // Sinks one burst and checks every beat
  // With fixed ready every beat must follow the previous one at once
  task automatic receive_burst(input int length, input logic [31:0] first,
                               input bit random_ready);
    int idle;
    for (int k = 0; k < length; k++) begin
      idle = 0;
      forever begin
        next_cycle();
        m_ready = random_ready ? 1'($random(seed)) : 1'b1;
        if (m_valid && m_ready) break;
        idle++;
        if (idle >= BEAT_TIMEOUT) begin
          $display("Timeout: beat %0d of the burst never arrived", k);
          abort_run();
        end
      end
      if (!random_ready && k > 0) begin
        check_equal(idle, 0, "idle cycles between beats");
      end
      check_equal(m_beat.data, first + 32'(k), "beat data");
      check_equal(m_beat.last, (k == length - 1), "beat last");
    end
  endtask

  // A missing or repeated beat would show up here as an extra valid
  task automatic expect_no_beat(input int cycles);
    repeat (cycles) begin
      next_cycle();
      m_ready = 1'b1;
      check_equal(m_valid, 1'b0, "m_valid with no burst running");
    end
  endtask

  task automatic wait_done();
    logic [31:0] status;
    int polls;
    polls = 0;
    do begin
      wb_read(REG_CTRL, status);
      polls++;
      if (status[1] !== 1'b1 && polls >= POLL_TIMEOUT) begin
        $display("Timeout: the controller never reported the burst as done");
        abort_run();
      end
    end while (status[1] !== 1'b1);
  endtask

  // **********************************************************************
  // Directed tests
  // **********************************************************************

  task automatic test_reset_and_regs();
    check_equal(m_valid, 1'b0, "m_valid after reset");
    read_check(REG_CTRL, 32'h0, "CTRL after reset");
    wb_write(REG_LENGTH, 32'h0000_1234);
    read_check(REG_LENGTH, 32'h0000_1234, "LENGTH readback");
    wb_write(REG_START, 32'hDEAD_BEEF);
    read_check(REG_START, 32'hDEAD_BEEF, "START readback");
    // Read-only and unmapped words
    wb_write(REG_BEATS, 32'h55);
    read_check(REG_BEATS, 32'h0, "BEATS after ignored write");
    read_check(3'd7, 32'h0, "unmapped read");
  endtask

  task automatic test_short_burst();
    m_ready = 1'b0;
    start_burst(8, 32'd100);
    receive_burst(8, 32'd100, 1'b0);
    expect_no_beat(4);
    wait_done();
    read_check(REG_BEATS, 32'd8, "BEATS after short burst");
    read_check(REG_SUM, ramp_sum(32'd100, 8), "SUM after short burst");
  endtask

  task automatic test_wrap_burst();
    m_ready = 1'b0;
    start_burst(40, 32'hFFFF_FFF0);
    wait_for_valid();
    // Ready is still low, so the burst is stalled in the slice
    read_check(REG_CTRL, 32'h1, "CTRL during stalled burst");
    receive_burst(40, 32'hFFFF_FFF0, 1'b1);
    expect_no_beat(4);
    wait_done();
    read_check(REG_CTRL, 32'h2, "CTRL after burst");
    read_check(REG_BEATS, 32'd40, "BEATS after wrapping burst");
    read_check(REG_SUM, ramp_sum(32'hFFFF_FFF0, 40), "SUM after wrapping burst");
  endtask

  task automatic test_ignored_starts();
    m_ready = 1'b0;
    start_burst(6, 32'd500);
    wait_for_valid();
    // Second start while busy must leave the running burst alone
    wb_write(REG_START, 32'd9000);
    wb_write(REG_CTRL, 32'h1);
    receive_burst(6, 32'd500, 1'b0);
    expect_no_beat(4);
    wait_done();
    read_check(REG_BEATS, 32'd6, "BEATS after busy start");
    wb_write(REG_LENGTH, 32'h0);
    wb_write(REG_CTRL, 32'h1);
    read_check(REG_CTRL, 32'h2, "CTRL after zero length start");
    expect_no_beat(20);
    read_check(REG_BEATS, 32'd6, "BEATS after zero length start");
  endtask

  initial begin
    resetn = 1'b0;
    wb_req = '0;
    m_ready = 1'b0;
    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    resetn = 1'b1;
    test_reset_and_regs();
    test_short_burst();
    test_wrap_burst();
    test_ignored_starts();
    // Protocol assertions in the bound checker count towards the result
    if (dut_i.props_i.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Protocol assertions on the stream or bus failed during the run");
      abort_run();
    end
  end

endmodule : pattern_source_tb

/* tests/pattern_source_properties.sv */
module pattern_source_properties
  import stream_pkg::*;
  import regmap_pkg::*;
(
  input logic         clk,
  input logic         resetn,
  input wb_req_t      wb_req,
  input logic         wb_ack,
  input logic         m_valid,
  input logic         m_ready,
  input stream_beat_t m_beat,
  input ctrl_state_e  state
);

  timeunit 1ns;
  timeprecision 100ps;

  // Number of assertion failures seen so far
  int fail_count = 0;

  // **********************************************************************
  // Stream protocol on the outer port
  // **********************************************************************

  // A stalled beat must be held unchanged until it is taken
  stall_holds_beat: assert property (
    @(posedge clk) disable iff (!resetn)
    (m_valid && !m_ready) |=> (m_valid && $stable(m_beat))
  ) else begin
    fail_count++;
    $error("Stream beat changed or dropped while stalled");
  end

  // The stream is quiet right after reset
  valid_low_after_reset: assert property (
    @(posedge clk) !resetn |=> !m_valid
  ) else begin
    fail_count++;
    $error("m_valid high in the cycle after reset");
  end

  // Nothing may leave while the controller has no burst running
  idle_means_quiet: assert property (
    @(posedge clk) disable iff (!resetn)
    (state == ST_IDLE) |-> !m_valid
  ) else begin
    fail_count++;
    $error("m_valid high while the controller is idle");
  end

  // **********************************************************************
  // Wishbone slave
  // **********************************************************************

  ack_follows_stb: assert property (
    @(posedge clk) disable iff (!resetn)
    $rose(wb_ack) |-> $past(wb_req.stb)
  ) else begin
    fail_count++;
    $error("wb_ack rose without a strobe in the cycle before");
  end

endmodule : pattern_source_properties

bind pattern_source_top pattern_source_properties props_i (
  .clk     (clk),
  .resetn  (resetn),
  .wb_req  (wb_req),
  .wb_ack  (wb_ack),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_beat  (m_beat),
  .state   (u_ctrl.state)
);

/* src/pattern_source_top.sv */
module pattern_source_top
  import stream_pkg::*;
  import regmap_pkg::*;
#(
  parameter int FORWARD_REGISTERED  = 1,
  parameter int BACKWARD_REGISTERED = 1
) (
  input  logic                 clk,
  input  logic                 resetn,

  // Host register port
  input  wb_req_t              wb_req,
  output logic                 wb_ack,
  output logic [WB_DATA_W-1:0] wb_dat_r,

  // Pattern stream out
  output logic                 m_valid,
  input  logic                 m_ready,
  output stream_beat_t         m_beat
);

  // Controller to generator and monitor
  logic                     start;
  logic                     clear;
  logic [BURST_LEN_W-1:0]   length;
  logic [STREAM_DATA_W-1:0] start_value;

  // Monitor status back to the controller
  logic                     last_seen;
  logic [BURST_LEN_W-1:0]   beat_count;
  logic [STREAM_DATA_W-1:0] data_sum;

  // Inner hop between generator and slice
  logic                     gen_valid;
  logic                     gen_ready;
  stream_beat_t             gen_beat;

  pattern_ctrl u_ctrl (
    .clk         (clk),
    .resetn      (resetn),
    .wb_req      (wb_req),
    .wb_ack      (wb_ack),
    .wb_dat_r    (wb_dat_r),
    .start       (start),
    .clear       (clear),
    .length      (length),
    .start_value (start_value),
    .last_seen   (last_seen),
    .beat_count  (beat_count),
    .data_sum    (data_sum)
  );

  pattern_gen u_gen (
    .clk         (clk),
    .resetn      (resetn),
    .start       (start),
    .length      (length),
    .start_value (start_value),
    .valid       (gen_valid),
    .ready       (gen_ready),
    .beat        (gen_beat)
  );

  axi_register_slice #(
    .FORWARD_REGISTERED  (FORWARD_REGISTERED),
    .BACKWARD_REGISTERED (BACKWARD_REGISTERED)
  ) u_slice (
    .clk     (clk),
    .resetn  (resetn),
    .s_valid (gen_valid),
    .s_ready (gen_ready),
    .s_beat  (gen_beat),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_beat  (m_beat)
  );

  // Watches the outer port, so the counts reflect what actually left
  stream_monitor u_monitor (
    .clk        (clk),
    .resetn     (resetn),
    .clear      (clear),
    .valid      (m_valid),
    .ready      (m_ready),
    .beat       (m_beat),
    .beat_count (beat_count),
    .data_sum   (data_sum),
    .last_seen  (last_seen)
  );

endmodule : pattern_source_top

/* src/pattern_ctrl.sv */
module pattern_ctrl
  import stream_pkg::*;
  import regmap_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetn,

  // Wishbone classic slave port
  input  wb_req_t                  wb_req,
  output logic                     wb_ack,
  output logic [WB_DATA_W-1:0]     wb_dat_r,

  // Burst control towards the generator and the monitor
  output logic                     start,
  output logic                     clear,
  output logic [BURST_LEN_W-1:0]   length,
  output logic [STREAM_DATA_W-1:0] start_value,

  // Status back from the output monitor
  input  logic                     last_seen,
  input  logic [BURST_LEN_W-1:0]   beat_count,
  input  logic [STREAM_DATA_W-1:0] data_sum
);

  ctrl_state_e          state;
  reg_addr_e            bus_addr;
  logic                 bus_hold;
  logic                 bus_take;
  logic                 busy;
  logic                 done;
  logic                 start_req;
  logic                 start_ok;
  logic [WB_DATA_W-1:0] rd_data;

  // ********************************************************************
  // Bus handshake
  // ********************************************************************

  // A request is served once, then the slave waits for stb to drop
  assign bus_take = wb_req.cyc && wb_req.stb && !wb_ack && !bus_hold;
  assign bus_addr = reg_addr_e'(wb_req.adr);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wb_ack   <= 1'b0;
      bus_hold <= 1'b0;
    end else begin
      wb_ack <= bus_take;
      // Hold off a second ack until the master has released stb
      if (!wb_req.stb) begin
        bus_hold <= 1'b0;
      end else if (wb_ack) begin
        bus_hold <= 1'b1;
      end
    end
  end

  // Read mux, unmapped words return zero
  always_comb begin
    case (bus_addr)
      REG_CTRL:   rd_data = {{(WB_DATA_W - 2){1'b0}}, done, busy};
      REG_LENGTH: rd_data = WB_DATA_W'(length);
      REG_START:  rd_data = WB_DATA_W'(start_value);
      REG_BEATS:  rd_data = WB_DATA_W'(beat_count);
      REG_SUM:    rd_data = WB_DATA_W'(data_sum);
      default:    rd_data = '0;
    endcase
  end

  // Read data is sampled together with the rising ack
  always_ff @(posedge clk) begin
    if (bus_take) begin
      wb_dat_r <= rd_data;
    end
  end

  // ********************************************************************
  // Register writes and burst FSM
  // ********************************************************************

  assign busy      = (state == ST_RUN);
  assign start_req = bus_take && wb_req.we && (bus_addr == REG_CTRL) && wb_req.dat[0];
  // Starts while running or with a zero length are dropped silently
  assign start_ok  = start_req && (state == ST_IDLE) && (length != '0);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      length      <= '0;
      start_value <= '0;
    end else if (bus_take && wb_req.we) begin
      // Read-only and unmapped words fall through without effect
      if (bus_addr == REG_LENGTH) begin
        length <= wb_req.dat[BURST_LEN_W-1:0];
      end
      if (bus_addr == REG_START) begin
        start_value <= wb_req.dat[STREAM_DATA_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= ST_IDLE;
      done  <= 1'b0;
      start <= 1'b0;
      clear <= 1'b0;
    end else begin
      // Start and clear leave in the same cycle, right after the ack edge
      start <= start_ok;
      clear <= start_ok;
      case (state)
        ST_IDLE: begin
          if (start_ok) begin
            state <= ST_RUN;
            done  <= 1'b0;
          end
        end
        ST_RUN: begin
          // Done stays set until the next accepted start
          if (last_seen) begin
            state <= ST_IDLE;
            done  <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule : pattern_ctrl

/* src/stream_monitor.sv */
module stream_monitor
  import stream_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetn,

  // Zeroes both counters at the start of a burst
  input  logic                     clear,

  // Observed hop, only sampled and never driven
  input  logic                     valid,
  input  logic                     ready,
  input  stream_beat_t             beat,

  output logic [BURST_LEN_W-1:0]   beat_count,
  output logic [STREAM_DATA_W-1:0] data_sum,
  output logic                     last_seen
);

  logic handshake;

  // A beat counts only when both sides agree in the same cycle
  assign handshake = valid && ready;

  // ********************************************************************
  // Beat counter, running sum and end-of-burst flag
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (!resetn) begin
      beat_count <= '0;
      data_sum   <= '0;
      last_seen  <= 1'b0;
    end else if (clear) begin
      beat_count <= '0;
      data_sum   <= '0;
      last_seen  <= 1'b0;
    end else begin
      // Single-cycle pulse in the cycle the counters take the last beat
      last_seen <= handshake && beat.last;
      if (handshake) begin
        beat_count <= beat_count + BURST_LEN_W'(1);
        // Sum is modulo the word width, as the host expects
        data_sum   <= data_sum + beat.data;
      end
    end
  end

endmodule : stream_monitor

/* src/pattern_gen.sv */
module pattern_gen
  import stream_pkg::*;
(
  input  logic                     clk,
  input  logic                     resetn,

  // One-cycle start pulse with the burst parameters beside it
  input  logic                     start,
  input  logic [BURST_LEN_W-1:0]   length,
  input  logic [STREAM_DATA_W-1:0] start_value,

  // Output stream
  output logic                     valid,
  input  logic                     ready,
  output stream_beat_t             beat
);

  // Beats still to send, including the one on the output now
  logic [BURST_LEN_W-1:0]   remaining;
  // Data word of the beat on the output now
  logic [STREAM_DATA_W-1:0] value;
  logic                     is_last;
  logic                     handshake;

  // The final beat is the one with a single beat left
  assign is_last   = (remaining == BURST_LEN_W'(1));
  assign handshake = valid && ready;

  // ********************************************************************
  // Burst sequencing
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid     <= 1'b0;
      remaining <= '0;
      value     <= '0;
    end else if (start) begin
      // The controller only starts with a non-zero length
      valid     <= 1'b1;
      remaining <= length;
      value     <= start_value;
    end else if (handshake) begin
      if (is_last) begin
        valid <= 1'b0;
      end
      // Ramp wraps naturally at the word width
      value     <= value + STREAM_DATA_W'(1);
      remaining <= remaining - BURST_LEN_W'(1);
    end
  end

  // Without a handshake nothing above moves, so the beat is held
  assign beat.data = value;
  assign beat.last = is_last;

endmodule : pattern_gen

/* src/axi_register_slice.sv */
module axi_register_slice
  import stream_pkg::*;
#(
  parameter int FORWARD_REGISTERED  = 1,
  parameter int BACKWARD_REGISTERED = 1
) (
  input  logic         clk,
  input  logic         resetn,

  input  logic         s_valid,
  output logic         s_ready,
  input  stream_beat_t s_beat,

  output logic         m_valid,
  input  logic         m_ready,
  output stream_beat_t m_beat
);

  // Data path through the stage
  //   s_beat  -> bwd_beat  -> fwd_beat  -> m_beat
  //   s_valid -> bwd_valid -> fwd_valid -> m_valid
  //   s_ready <- bwd_ready <- fwd_ready <- m_ready
  // The backward stage breaks the ready path, the forward stage breaks
  // the valid and data path
  stream_beat_t bwd_beat;
  logic         bwd_valid;
  logic         bwd_ready;
  stream_beat_t fwd_beat;
  logic         fwd_valid;
  logic         fwd_ready;

  // ********************************************************************
  // Backward stage, a one-entry skid buffer
  // ********************************************************************

  if (BACKWARD_REGISTERED != 0) begin : g_bwd_reg
    logic         skid_ready;
    stream_beat_t skid_beat;

    // Capture every offered beat while empty, so a stall from the
    // forward side always finds the beat already parked here
    always_ff @(posedge clk) begin
      if (skid_ready) begin
        skid_beat <= s_beat;
      end
    end

    // Go not-ready when a beat arrives that the forward side cannot take
    always_ff @(posedge clk) begin
      if (!resetn) begin
        skid_ready <= 1'b1;
      end else if (fwd_ready) begin
        skid_ready <= 1'b1;
      end else if (s_valid) begin
        skid_ready <= 1'b0;
      end
    end

    // A parked beat takes priority over the input
    assign bwd_valid = !skid_ready || s_valid;
    assign bwd_beat  = skid_ready ? s_beat : skid_beat;
    assign bwd_ready = skid_ready;
  end else begin : g_bwd_wire
    assign bwd_valid = s_valid;
    assign bwd_beat  = s_beat;
    assign bwd_ready = fwd_ready;
  end

  // ********************************************************************
  // Forward stage, a plain output register
  // ********************************************************************

  if (FORWARD_REGISTERED != 0) begin : g_fwd_reg
    logic         out_valid;
    stream_beat_t out_beat;

    // The register can load when it is empty or being drained
    assign fwd_ready = !out_valid || m_ready;

    always_ff @(posedge clk) begin
      if (fwd_ready) begin
        out_beat <= bwd_beat;
      end
    end

    always_ff @(posedge clk) begin
      if (!resetn) begin
        out_valid <= 1'b0;
      end else if (fwd_ready) begin
        out_valid <= bwd_valid;
      end
    end

    assign fwd_valid = out_valid;
    assign fwd_beat  = out_beat;
  end else begin : g_fwd_wire
    assign fwd_ready = m_ready;
    assign fwd_valid = bwd_valid;
    assign fwd_beat  = bwd_beat;
  end

  assign m_valid = fwd_valid;
  assign m_beat  = fwd_beat;
  assign s_ready = bwd_ready;

endmodule : axi_register_slice

/* src/regmap_pkg.sv */
// **********************************************************************
// Host side definitions for the Wishbone register map
// **********************************************************************

package regmap_pkg;

  // Word address width of the register window
  localparam int WB_ADDR_W = 3;

  // Data width of the host bus, with one select bit per byte
  localparam int WB_DATA_W = 32;
  localparam int WB_SEL_W  = WB_DATA_W / 8;

  // Register word addresses
  // CTRL takes a start in bit 0 on write and returns busy and done on read
  // BEATS and SUM are read only and reflect the output monitor
  typedef enum logic [WB_ADDR_W-1:0] {
    REG_CTRL   = 3'd0,
    REG_LENGTH = 3'd1,
    REG_START  = 3'd2,
    REG_BEATS  = 3'd3,
    REG_SUM    = 3'd4
  } reg_addr_e;

  // Burst controller states
  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RUN  = 1'b1
  } ctrl_state_e;

  // Master to slave half of a Wishbone classic cycle
  // The select lanes are carried but the slave always writes whole words
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADDR_W-1:0] adr;
    logic [WB_DATA_W-1:0] dat;
    logic [WB_SEL_W-1:0]  sel;
  } wb_req_t;

endpackage : regmap_pkg

/* src/stream_pkg.sv */
// **********************************************************************
// Stream side definitions shared by the pattern source blocks
// **********************************************************************

package stream_pkg;

  // Width of one data word on the stream
  localparam int STREAM_DATA_W = 32;

  // Width of the burst length register and of the beat counters
  // A burst can therefore be up to 65535 beats long
  localparam int BURST_LEN_W = 16;

  // One beat of the output stream
  // The struct travels on every hop as a single packed vector, so the
  // slice and the monitor never have to know the field layout
  typedef struct packed {
    // Payload word of the beat
    logic [STREAM_DATA_W-1:0] data;
    // High on the final beat of a burst only
    logic                     last;
  } stream_beat_t;

  // The handshake itself is not part of the struct
  // Valid and ready run next to it as separate wires, because ready
  // flows against the direction of the beat

endpackage : stream_pkg
